//--- frame_store.sv
`default_nettype none

module frame_store (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cmd_capture,
    input  logic                                cmd_readout,
    input  logic                                frame_done,
    word_stream_if.sink                         in,
    output logic                                readout_valid,
    output stream_pkg::stream_word_u            readout_data,
    output logic [stream_pkg::STORE_ADDR_W-1:0] word_count,
    output logic                                capture_done,
    input  logic                                readout_ready
);

    stream_pkg::stream_word_u               ram [stream_pkg::STORE_DEPTH];
    logic [stream_pkg::STORE_ADDR_W-1:0]    rd_addr;
    logic                                   reading;
    logic                                   done_seen;
    logic                                   wr_en;
    logic                                   rd_fire;

    // No intake while the store is being read out
    assign in.ready = !reading;
    assign wr_en = in.valid && in.ready && int'(word_count) < stream_pkg::STORE_DEPTH;
    // Refill the output register when it is empty or being taken
    assign rd_fire = reading && rd_addr < word_count && (!readout_valid || readout_ready);

    always_ff @(posedge clk) begin
        if (wr_en)   ram[word_count[stream_pkg::STORE_ADDR_W-2:0]] <= in.word;
        if (rd_fire) readout_data <= ram[rd_addr[stream_pkg::STORE_ADDR_W-2:0]];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_count <= '0;
            rd_addr <= '0;
            reading <= 1'b0;
            readout_valid <= 1'b0;
            done_seen <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            capture_done <= 1'b0;
            if (wr_en) word_count <= word_count + 1'b1;

            // End of capture once the FIFO has drained
            if (frame_done) begin
                done_seen <= 1'b1;
            end else if (done_seen && !in.valid) begin
                done_seen <= 1'b0;
                capture_done <= 1'b1;
            end

            if (rd_fire) begin
                readout_valid <= 1'b1;
                rd_addr <= rd_addr + 1'b1;
            end else if (readout_valid && readout_ready) begin
                readout_valid <= 1'b0;
            end

            if (reading && rd_addr == word_count && (!readout_valid || readout_ready)) begin
                reading <= 1'b0;
            end

            if (cmd_capture) begin
                word_count <= '0;
                done_seen <= 1'b0;
            end
            if (cmd_readout) begin
                reading <= 1'b1;
                rd_addr <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- img_capture_assertions.sv
`default_nettype none

module img_capture_assertions (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cmd_capture,
    input  logic                                    readout_valid,
    input  logic [stream_pkg::WORD_W-1:0]           readout_data,
    input  logic                                    readout_ready,
    input  logic                                    status_capture_done,
    input  logic [$clog2(stream_pkg::FIFO_DEPTH):0] fifo_count
);

    timeunit 1ns;
    timeprecision 1ps;

    logic capturing;
    int   hold_fails;
    int   done_fails;
    int   depth_fails;
    int   busy_fails;
    int   fail_count;

    initial begin
        hold_fails = 0;
        done_fails = 0;
        depth_fails = 0;
        busy_fails = 0;
    end

    assign fail_count = hold_fails + done_fails + depth_fails + busy_fails;

    // Capture runs from the command until the done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            capturing <= 1'b0;
        end else if (cmd_capture) begin
            capturing <= 1'b1;
        end else if (status_capture_done) begin
            capturing <= 1'b0;
        end
    end

    // ============================================================
    // Protocol properties
    // ============================================================
    readout_hold: assert property (@(posedge clk) disable iff (!rst_n)
        readout_valid && !readout_ready |=> readout_valid && $stable(readout_data))
        else begin
            $error("readout word changed under back-pressure");
            hold_fails++;
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        status_capture_done |=> !status_capture_done)
        else begin
            $error("capture done pulse longer than one cycle");
            done_fails++;
        end

    fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
        int'(fifo_count) <= stream_pkg::FIFO_DEPTH)
        else begin
            $error("word FIFO holds more words than its depth");
            depth_fails++;
        end

    no_readout_in_capture: assert property (@(posedge clk) disable iff (!rst_n)
        capturing |-> !readout_valid)
        else begin
            $error("readout valid during a capture");
            busy_fails++;
        end

endmodule

`default_nettype wire

//--- img_capture_top.sv
`default_nettype none

module img_capture_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // Commands
    input  logic                                cmd_capture,
    input  logic                                cmd_readout,
    input  logic [img_pkg::HEADER_W-1:0]        cmd_header,
    // Image sensor
    input  logic [img_pkg::PIXEL_W-1:0]         img_d,
    input  logic                                img_fv,
    input  logic                                img_lv,
    // Readout stream
    output logic                                readout_valid,
    output logic [stream_pkg::WORD_W-1:0]       readout_data,
    input  logic                                readout_ready,
    // Status
    output logic                                status_capture_done,
    output logic [stream_pkg::STORE_ADDR_W-1:0] status_word_count,
    output logic [img_pkg::STAT_COUNT_W-1:0]    status_highlight_count,
    output logic [img_pkg::STAT_COUNT_W-1:0]    status_shadow_count,
    output logic                                status_overflow
);

    logic                       frame_done;
    stream_pkg::stream_word_u   readout_word;

    word_stream_if framer_to_fifo ();
    word_stream_if fifo_to_store ();

    assign readout_data = readout_word.raw;

    pixel_framer framer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_capture     (cmd_capture),
        .cmd_header      (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .frame_done      (frame_done),
        .highlight_count (status_highlight_count),
        .shadow_count    (status_shadow_count),
        .overflow        (status_overflow),
        .out             (framer_to_fifo.source)
    );

    word_fifo fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (framer_to_fifo.sink),
        .out   (fifo_to_store.source)
    );

    frame_store store_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_capture   (cmd_capture),
        .cmd_readout   (cmd_readout),
        .frame_done    (frame_done),
        .in            (fifo_to_store.sink),
        .readout_valid (readout_valid),
        .readout_data  (readout_word),
        .word_count    (status_word_count),
        .capture_done  (status_capture_done),
        .readout_ready (readout_ready)
    );

endmodule

`default_nettype wire

//--- img_pkg.sv
`default_nettype none

package img_pkg;

    // ============================================================
    // Image format
    // ============================================================
    localparam int PIXEL_W = 12;
    localparam int HEADER_WORDS = 4;
    localparam int HEADER_W = 64;

    // ============================================================
    // Highlight / shadow statistics
    // ============================================================
    // Top bits of a pixel tested against all ones or all zeros
    localparam int STAT_BITS = 7;
    localparam int STAT_COUNT_W = 18;
    // Phase counter width, one sample per 4x4 block
    localparam int SAMPLE_STRIDE_W = 2;

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [STAT_COUNT_W-1:0] stat_count_t;

endpackage

`default_nettype wire

//--- pixel_framer.sv
`default_nettype none

module pixel_framer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cmd_capture,
    input  logic [img_pkg::HEADER_W-1:0]    cmd_header,
    input  img_pkg::pixel_t                 img_d,
    input  logic                            img_fv,
    input  logic                            img_lv,
    output logic                            frame_done,
    output img_pkg::stat_count_t            highlight_count,
    output img_pkg::stat_count_t            shadow_count,
    output logic                            overflow,
    word_stream_if.source                   out
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_HEADER, ST_WAIT_FRAME, ST_FRAME, ST_CK_HI, ST_CK_LO
    } state_t;

    state_t                                     state;
    logic [$clog2(img_pkg::HEADER_WORDS)-1:0]   hdr_cnt;
    logic [img_pkg::HEADER_W-1:0]               header_sr;
    logic [stream_pkg::WORD_W-1:0]              sum_a;
    logic [stream_pkg::WORD_W-1:0]              sum_b;
    logic [stream_pkg::WORD_W-1:0]              a_next;
    logic [stream_pkg::WORD_W-1:0]              b_next;
    logic                                       fv_prev;
    logic                                       lv_prev;
    logic                                       fv_rise;
    logic                                       pixel_en;
    logic [img_pkg::SAMPLE_STRIDE_W-1:0]        x_phase;
    logic [img_pkg::SAMPLE_STRIDE_W-1:0]        y_phase;
    logic                                       sample_en;
    img_pkg::pixel_t                            sample_px;
    logic [img_pkg::STAT_BITS-1:0]              sample_top;
    logic                                       done_pend;
    logic                                       emit_data;
    logic                                       emit_ck;
    stream_pkg::stream_word_u                   emit_word;

    // Addition modulo 2^16-1 for the Fletcher sums
    function automatic logic [stream_pkg::WORD_W-1:0] mod_add(
        input logic [stream_pkg::WORD_W-1:0] x,
        input logic [stream_pkg::WORD_W-1:0] y
    );
        logic [stream_pkg::WORD_W:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, {stream_pkg::WORD_W{1'b1}}}) begin
            s = s - {1'b0, {stream_pkg::WORD_W{1'b1}}};
        end
        return s[stream_pkg::WORD_W-1:0];
    endfunction

    assign fv_rise = img_fv && !fv_prev;
    // A pixel on the very first line cycle of the frame is kept too
    assign pixel_en = img_fv && img_lv &&
                      (state == ST_FRAME || (state == ST_WAIT_FRAME && fv_rise));
    assign sample_top = sample_px[img_pkg::PIXEL_W-1 -: img_pkg::STAT_BITS];
    assign a_next = mod_add(sum_a, emit_word.raw);
    assign b_next = mod_add(sum_b, a_next);

    // ============================================================
    // Word selection
    // ============================================================
    always_comb begin
        emit_word = '0;
        emit_data = 1'b0;
        emit_ck = 1'b0;
        case (state)
            ST_HEADER: begin
                emit_data = 1'b1;
                emit_word.raw = header_sr[img_pkg::HEADER_W-1 -: stream_pkg::WORD_W];
            end
            ST_WAIT_FRAME, ST_FRAME: begin
                emit_data = pixel_en;
                emit_word.pixel.px = img_d;
            end
            ST_CK_HI: begin
                emit_ck = 1'b1;
                emit_word.raw = sum_b;
            end
            ST_CK_LO: begin
                emit_ck = 1'b1;
                emit_word.raw = sum_a;
            end
            default: ;
        endcase
    end

    // ============================================================
    // Control, checksum and statistics
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            hdr_cnt <= '0;
            sum_a <= '0;
            sum_b <= '0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
            x_phase <= '0;
            y_phase <= '0;
            sample_en <= 1'b0;
            highlight_count <= '0;
            shadow_count <= '0;
            overflow <= 1'b0;
            done_pend <= 1'b0;
            frame_done <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            fv_prev <= img_fv;
            lv_prev <= img_lv;
            out.valid <= emit_data || emit_ck;
            done_pend <= 1'b0;
            frame_done <= done_pend;
            sample_en <= pixel_en && x_phase == '0 && y_phase == '0;

            if (!img_lv) x_phase <= '0;
            else         x_phase <= x_phase + 1'b1;

            if (!img_fv)                   y_phase <= '0;
            else if (lv_prev && !img_lv)   y_phase <= y_phase + 1'b1;

            // The buffer cannot stall a camera, so a refused word is lost
            if (out.valid && !out.ready) overflow <= 1'b1;

            if (emit_data) begin
                sum_a <= a_next;
                sum_b <= b_next;
            end

            if (sample_en) begin
                if (&sample_top)        highlight_count <= highlight_count + 1'b1;
                else if (~|sample_top)  shadow_count <= shadow_count + 1'b1;
            end

            case (state)
                ST_HEADER: begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (int'(hdr_cnt) == img_pkg::HEADER_WORDS - 1) state <= ST_WAIT_FRAME;
                end
                ST_WAIT_FRAME: if (fv_rise) state <= ST_FRAME;
                ST_FRAME:      if (!img_fv) state <= ST_CK_HI;
                ST_CK_HI:      state <= ST_CK_LO;
                ST_CK_LO: begin
                    state <= ST_IDLE;
                    done_pend <= 1'b1;
                end
                default: ;
            endcase

            if (cmd_capture) begin
                state <= ST_HEADER;
                hdr_cnt <= '0;
                sum_a <= '0;
                sum_b <= '0;
                highlight_count <= '0;
                shadow_count <= '0;
                overflow <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        sample_px <= img_d;
        if (emit_data || emit_ck) out.word <= emit_word;
        if (cmd_capture)             header_sr <= cmd_header;
        else if (state == ST_HEADER) header_sr <= header_sr << stream_pkg::WORD_W;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the image capture testbench with Verilator

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_img_capture -f src.f \
    -Mdir "$BUILD_DIR" -o sim_img_capture
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running after assertion errors so the testbench can report them
"./$BUILD_DIR/sim_img_capture" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

//--- src.f
img_pkg.sv
stream_pkg.sv
word_stream_if.sv
pixel_framer.sv
word_fifo.sv
frame_store.sv
img_capture_top.sv
img_capture_assertions.sv
tb_img_capture.sv

//--- stream_pkg.sv
`default_nettype none

package stream_pkg;

    localparam int WORD_W = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int STORE_DEPTH = 256;
    // One bit wider than the RAM address so a full count of STORE_DEPTH fits
    localparam int STORE_ADDR_W = 9;

    // Header and checksum words use the raw view, pixels the pixel view
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic [WORD_W-img_pkg::PIXEL_W-1:0] pad;
            img_pkg::pixel_t px;
        } pixel;
    } stream_word_u;

endpackage

`default_nettype wire

//--- tb_img_capture.sv
`default_nettype none

module tb_img_capture;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES = 2;
    localparam int LINES = 8;
    localparam int MIN_LINE = 16;
    localparam int MAX_LINE = 28;
    localparam int LINE_BLANK = 4;
    localparam int FRAME_CYCLES = LINES * (MAX_LINE + LINE_BLANK) + 40;
    localparam int READOUT_CYCLES = stream_pkg::STORE_DEPTH * 4;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (FRAME_CYCLES + READOUT_CYCLES) * 4;
    localparam int HW = img_pkg::HEADER_WORDS;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   cmd_capture;
    logic                                   cmd_readout;
    logic [img_pkg::HEADER_W-1:0]           cmd_header;
    logic [img_pkg::PIXEL_W-1:0]            img_d;
    logic                                   img_fv;
    logic                                   img_lv;
    logic                                   readout_valid;
    logic [stream_pkg::WORD_W-1:0]          readout_data;
    logic                                   readout_ready;
    logic                                   status_capture_done;
    logic [stream_pkg::STORE_ADDR_W-1:0]    status_word_count;
    logic [img_pkg::STAT_COUNT_W-1:0]       status_highlight_count;
    logic [img_pkg::STAT_COUNT_W-1:0]       status_shadow_count;
    logic                                   status_overflow;

    // Reference model of the current frame
    logic [stream_pkg::WORD_W-1:0]  exp_q[$];
    img_pkg::pixel_t                exp_px[$];
    int                             exp_highlight;
    int                             exp_shadow;
    int                             errors;

    img_capture_top dut_i (.*);

    bind img_capture_top img_capture_assertions assertions_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .cmd_capture         (cmd_capture),
        .readout_valid       (readout_valid),
        .readout_data        (readout_data),
        .readout_ready       (readout_ready),
        .status_capture_done (status_capture_done),
        .fifo_count          (fifo_i.count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // Sampled pixels are forced to highlight or shadow two times out of three
    function automatic img_pkg::pixel_t make_pixel(input logic sampled);
        logic [31:0] r;
        int          sel;
        r = $urandom;
        sel = int'($urandom % 3);
        if (sampled && sel == 0) begin
            r[img_pkg::PIXEL_W-1 -: img_pkg::STAT_BITS] = '1;
        end else if (sampled && sel == 1) begin
            r[img_pkg::PIXEL_W-1 -: img_pkg::STAT_BITS] = '0;
        end
        return r[img_pkg::PIXEL_W-1:0];
    endfunction

    // ============================================================
    // Capture one frame and build its expected word list
    // ============================================================
    task automatic capture_frame();
        logic [31:0]        r_hi;
        logic [31:0]        r_lo;
        img_pkg::pixel_t    px;
        logic               sampled;
        int                 i;
        int                 line;
        int                 col;
        int                 line_len;
        int                 a;
        int                 b;
        exp_q.delete();
        exp_px.delete();
        exp_highlight = 0;
        exp_shadow = 0;
        @(negedge clk);
        r_hi = $urandom;
        r_lo = $urandom;
        cmd_header = {r_hi, r_lo};
        cmd_capture = 1'b1;
        @(negedge clk);
        cmd_capture = 1'b0;
        for (i = 0; i < HW; i++) begin
            exp_q.push_back(cmd_header[img_pkg::HEADER_W-1-stream_pkg::WORD_W*i -: 16]);
        end
        repeat (8) @(negedge clk);
        img_fv = 1'b1;
        repeat (LINE_BLANK) @(negedge clk);
        for (line = 0; line < LINES; line++) begin
            line_len = MIN_LINE + int'($urandom % (MAX_LINE - MIN_LINE + 1));
            for (col = 0; col < line_len; col++) begin
                sampled = (line % 4 == 0) && (col % 4 == 0);
                px = make_pixel(sampled);
                img_d = px;
                img_lv = 1'b1;
                exp_px.push_back(px);
                exp_q.push_back({4'h0, px});
                if (sampled && &px[img_pkg::PIXEL_W-1 -: img_pkg::STAT_BITS]) begin
                    exp_highlight++;
                end else if (sampled && ~|px[img_pkg::PIXEL_W-1 -: img_pkg::STAT_BITS]) begin
                    exp_shadow++;
                end
                @(negedge clk);
            end
            img_lv = 1'b0;
            img_d = make_pixel(1'b0);
            repeat (LINE_BLANK) @(negedge clk);
        end
        img_fv = 1'b0;
        // Fletcher sums modulo 65535, high word is b
        a = 0;
        b = 0;
        foreach (exp_q[k]) begin
            a = (a + int'(exp_q[k])) % 65535;
            b = (b + a) % 65535;
        end
        exp_q.push_back(16'(b));
        exp_q.push_back(16'(a));
        do @(negedge clk); while (!status_capture_done);
        check_value("word count", int'(status_word_count), exp_q.size());
        check_value("highlight count", int'(status_highlight_count), exp_highlight);
        check_value("shadow count", int'(status_shadow_count), exp_shadow);
        check_value("overflow flag", int'(status_overflow), 0);
    endtask

    // ============================================================
    // Read the store back under random back-pressure
    // ============================================================
    task automatic readout_frame();
        stream_pkg::stream_word_u   got_w;
        int                         idx;
        @(negedge clk);
        cmd_readout = 1'b1;
        idx = 0;
        while (idx < exp_q.size()) begin
            @(negedge clk);
            cmd_readout = 1'b0;
            readout_ready = ($urandom % 4) != 0;
            if (readout_valid && readout_ready) begin
                got_w = readout_data;
                if (idx >= HW && idx < HW + exp_px.size()) begin
                    check_value($sformatf("pixel of word %0d", idx),
                                int'(got_w.pixel.px), int'(exp_px[idx-HW]));
                    check_value($sformatf("pad of word %0d", idx), int'(got_w.pixel.pad), 0);
                end else begin
                    check_value($sformatf("word %0d", idx), int'(got_w.raw), int'(exp_q[idx]));
                end
                idx++;
            end
        end
        @(negedge clk);
        readout_ready = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("readout valid after last word", int'(readout_valid), 0);
        end
    endtask

    initial begin
        void'($urandom(76));
        errors = 0;
        rst_n = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_header = '0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        readout_ready = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("readout valid after reset", int'(readout_valid), 0);
        check_value("capture done after reset", int'(status_capture_done), 0);
        check_value("overflow after reset", int'(status_overflow), 0);
        check_value("word count after reset", int'(status_word_count), 0);
        check_value("highlight count after reset", int'(status_highlight_count), 0);
        check_value("shadow count after reset", int'(status_shadow_count), 0);
        repeat (NUM_FRAMES) begin
            capture_frame();
            readout_frame();
        end
        $display("Value errors: %0d, assertion failures: %0d",
                 errors, dut_i.assertions_i.fail_count);
        if (errors == 0 && dut_i.assertions_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- word_fifo.sv
`default_nettype none

module word_fifo (
    input  logic            clk,
    input  logic            rst_n,
    word_stream_if.sink     in,
    word_stream_if.source   out
);

    stream_pkg::stream_word_u                       mem [stream_pkg::FIFO_DEPTH];
    logic [$clog2(stream_pkg::FIFO_DEPTH)-1:0]      wr_ptr;
    logic [$clog2(stream_pkg::FIFO_DEPTH)-1:0]      rd_ptr;
    logic [$clog2(stream_pkg::FIFO_DEPTH):0]        count;
    logic                                           push;
    logic                                           pop;

    assign in.ready = int'(count) != stream_pkg::FIFO_DEPTH;
    assign out.valid = count != '0;
    assign out.word = mem[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in.word;
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- word_stream_if.sv
`default_nettype none

// Word stream with valid/ready handshake
// A word moves on a rising clk when valid and ready are both high
interface word_stream_if;

    logic valid;
    logic ready;
    stream_pkg::stream_word_u word;

    modport source (
        output valid,
        output word,
        input  ready
    );

    modport sink (
        input  valid,
        input  word,
        output ready
    );

endinterface

`default_nettype wire
